/* list.f */
common/irq_pkg.sv
common/exc_pkg.sv
irq_ctrl/irq_line_encoder.sv
irq_ctrl/interrupt_control.sv
rtl/exception_dispatch.sv
rtl/interrupt_subsystem.sv
verification/irq_checker.sv
verification/tb_interrupt_subsystem.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the interrupt subsystem testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f \
	--top-module tb_interrupt_subsystem -o sim_tb &&
sim_out="$(./obj_dir/sim_tb)" ; echo "$sim_out" &&
echo "$sim_out" | grep -qx "Test passed" && exit 0 || exit 1

/* verification/tb_interrupt_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_interrupt_subsystem;

	localparam logic [31:0] VEC_BASE   = 32'h0000_2000;
	localparam logic [31:0] VEC_STRIDE = 32'd32;
	localparam int          TEST_ITEMS = 16;

	logic                          iCLOCK = 1'b0;
	logic                          inRESET;
	logic [irq_pkg::IRQ_LINES-1:0] irq_req;
	logic                          ict_valid;
	irq_pkg::ext_num_t             ict_entry;
	logic                          ict_mask;
	logic                          ict_enable;
	logic                          fault_active;
	irq_pkg::irq_num_t             fault_num;
	exc_pkg::fault_info_t          fault_fi0;
	exc_pkg::fault_info_t          fault_fi1;
	logic                          handler_done;
	logic                          handler_valid;
	irq_pkg::irq_num_t             handler_num;
	logic [31:0]                   handler_vector;
	exc_pkg::fault_info_t          handler_fi0;
	exc_pkg::fault_info_t          handler_fi1;
	logic                          exception_pending;

	int tests_run = 0;
	int tests_failed = 0;

	interrupt_subsystem #(
		.VECTOR_BASE   (VEC_BASE),
		.VECTOR_STRIDE (VEC_STRIDE)
	) u_interrupt_subsystem (
		.iCLOCK (iCLOCK), .inRESET (inRESET), .irq_req (irq_req),
		.ict_valid (ict_valid), .ict_entry (ict_entry),
		.ict_mask (ict_mask), .ict_enable (ict_enable),
		.fault_active (fault_active), .fault_num (fault_num),
		.fault_fi0 (fault_fi0), .fault_fi1 (fault_fi1),
		.handler_done (handler_done), .handler_valid (handler_valid),
		.handler_num (handler_num), .handler_vector (handler_vector),
		.handler_fi0 (handler_fi0), .handler_fi1 (handler_fi1),
		.exception_pending (exception_pending)
	);

	irq_checker #(
		.VECTOR_BASE   (VEC_BASE),
		.VECTOR_STRIDE (VEC_STRIDE)
	) u_irq_checker (
		.iCLOCK (iCLOCK), .inRESET (inRESET), .irq_req (irq_req),
		.ict_valid (ict_valid), .ict_entry (ict_entry),
		.ict_mask (ict_mask), .ict_enable (ict_enable),
		.fault_active (fault_active), .fault_num (fault_num),
		.fault_fi0 (fault_fi0), .fault_fi1 (fault_fi1),
		.handler_done (handler_done), .handler_valid (handler_valid),
		.handler_num (handler_num), .handler_vector (handler_vector),
		.handler_fi0 (handler_fi0), .handler_fi1 (handler_fi1),
		.exception_pending (exception_pending)
	);

	always #4 iCLOCK = ~iCLOCK;

	initial begin : watchdog
		repeat (TEST_ITEMS * 200) @(posedge iCLOCK);
		$display("Timeout after %0d cycles without finishing the tests", TEST_ITEMS * 200);
		$display("Test failed");
		$finish;
	end

	// Core side, answers every handler after 1 to 6 cycles
	initial begin : core_model
		int delay;
		forever begin
			@(posedge iCLOCK);
			#1;
			if (handler_valid) begin
				delay = $urandom_range(6, 1);
				repeat (delay - 1) @(posedge iCLOCK);
				#1 handler_done = 1'b1;
				@(posedge iCLOCK);
				#1 handler_done = 1'b0;
			end
		end
	end

	task automatic write_entry(input int line, input logic mask, input logic enable);
		@(posedge iCLOCK);
		#1;
		ict_valid  = 1'b1;
		ict_entry  = irq_pkg::ext_num_t'(line);
		ict_mask   = mask;
		ict_enable = enable;
		@(posedge iCLOCK);
		#1 ict_valid = 1'b0;
	endtask

	// Burst on two cycles so the repeat pulse merges into the pending bit
	task automatic pulse_lines(input logic [irq_pkg::IRQ_LINES-1:0] lines);
		@(posedge iCLOCK);
		#1 irq_req = lines;
		@(posedge iCLOCK);
		#1 irq_req = lines;
		@(posedge iCLOCK);
		#1 irq_req = '0;
	endtask

	// With lines, the fault arrives while the first line's handler holds the lock
	// and meets the next line in the hardware latch when the lock drops
	task automatic raise_fault_with(input logic [irq_pkg::IRQ_LINES-1:0] lines);
		if (lines != '0) begin
			pulse_lines(lines);
			do begin
				@(posedge iCLOCK);
				#1;
			end while (!handler_valid);
		end else begin
			@(posedge iCLOCK);
			#1;
		end
		fault_active = 1'b1;
		fault_num    = irq_pkg::irq_num_t'($urandom());
		fault_fi0    = $urandom();
		fault_fi1    = $urandom();
		while (handler_valid) begin
			@(posedge iCLOCK);
			#1;
		end
		do begin
			@(posedge iCLOCK);
			#1;
		end while (!handler_valid);
		fault_active = 1'b0;
	endtask

	task automatic wait_quiet();
		do begin
			@(posedge iCLOCK);
			#1;
		end while (u_irq_checker.pend_model != '0 || handler_valid || fault_active);
		repeat (4) @(posedge iCLOCK);
	endtask

	function automatic logic [irq_pkg::IRQ_LINES-1:0] sparse_lines();
		logic [irq_pkg::IRQ_LINES-1:0] v;
		v = {$urandom(), $urandom()} & {$urandom(), $urandom()} & {$urandom(), $urandom()};
		if (v == '0) begin
			v[$urandom_range(63, 0)] = 1'b1;
		end
		return v;
	endfunction

	task automatic end_test(input string name, input int errs_before);
		int errs;
		errs = u_irq_checker.error_count - errs_before;
		tests_run++;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("%-10s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAIL", errs);
	endtask

	initial begin : stimulus
		int errs;
		int line;
		int count;
		void'($urandom(32'he5e860bd));
		inRESET = 1'b0;
		irq_req = '0;
		ict_valid = 1'b0;
		ict_entry = '0;
		ict_mask = 1'b0;
		ict_enable = 1'b0;
		fault_active = 1'b0;
		fault_num = '0;
		fault_fi0 = '0;
		fault_fi1 = '0;
		handler_done = 1'b0;
		repeat (4) @(posedge iCLOCK);
		#1 inRESET = 1'b1;

		errs = u_irq_checker.error_count;
		repeat (20) @(posedge iCLOCK);
		#1;
		if (u_irq_checker.dispatch_count != 0 || exception_pending) begin
			$display("Exception raised after reset without any request");
			u_irq_checker.error_count++;
		end
		end_test("reset", errs);

		errs = u_irq_checker.error_count;
		for (int i = 0; i < 4; i++) begin
			raise_fault_with('0);
			wait_quiet();
		end
		end_test("fault", errs);

		errs = u_irq_checker.error_count;
		for (int i = 0; i < 4; i++) begin
			pulse_lines(sparse_lines());
			wait_quiet();
		end
		end_test("hardware", errs);

		// Lines 0 and 63 make sure a second line waits behind the first handler
		errs = u_irq_checker.error_count;
		for (int i = 0; i < 4; i++) begin
			raise_fault_with(sparse_lines() | 64'h8000_0000_0000_0001);
			wait_quiet();
		end
		end_test("priority", errs);

		errs = u_irq_checker.error_count;
		line = $urandom_range(24, 5);
		write_entry(line, 1'b0, 1'b1);
		count = u_irq_checker.dispatch_count;
		pulse_lines((64'd1 << line) | (64'd1 << (line + 3)) | (64'd1 << (line + 9)));
		repeat (40) @(posedge iCLOCK);
		if (u_irq_checker.dispatch_count != count) begin
			$display("Masked line %0d let a handler through", line);
			u_irq_checker.error_count++;
		end
		write_entry(line, 1'b1, 1'b1);
		wait_quiet();
		if (u_irq_checker.dispatch_count != count + 3) begin
			$display("Released lines were not all dispatched");
			u_irq_checker.error_count++;
		end
		end_test("masking", errs);

		$display("Tests run %0d, failed %0d, dispatches %0d, errors %0d", tests_run,
			tests_failed, u_irq_checker.dispatch_count, u_irq_checker.error_count);
		if (tests_failed == 0 && u_irq_checker.error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verification/irq_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module irq_checker #(
	parameter logic [31:0] VECTOR_BASE   = 32'h0000_1000,
	parameter logic [31:0] VECTOR_STRIDE = 32'd16
) (
	input wire                          iCLOCK,
	input wire                          inRESET,
	input wire [irq_pkg::IRQ_LINES-1:0] irq_req,
	input wire                          ict_valid,
	input wire irq_pkg::ext_num_t       ict_entry,
	input wire                          ict_mask,
	input wire                          ict_enable,
	input wire                          fault_active,
	input wire irq_pkg::irq_num_t       fault_num,
	input wire exc_pkg::fault_info_t    fault_fi0,
	input wire exc_pkg::fault_info_t    fault_fi1,
	input wire                          handler_done,
	input wire                          handler_valid,
	input wire irq_pkg::irq_num_t       handler_num,
	input wire [31:0]                   handler_vector,
	input wire exc_pkg::fault_info_t    handler_fi0,
	input wire exc_pkg::fault_info_t    handler_fi1,
	input wire                          exception_pending
);

	int error_count = 0;
	int dispatch_count = 0;

	// Reference state of the pending lines and the table
	logic [irq_pkg::IRQ_LINES-1:0] pend_model = '0;
	logic [irq_pkg::IRQ_LINES-1:0] mask_model = '0;
	logic [irq_pkg::IRQ_LINES-1:0] enable_model = '0;
	logic hv_prev = 1'b0;
	logic outstanding = 1'b0;

	// Fault inputs of the last two cycles, index 1 is the acceptance cycle
	logic                 f_act_hist [2];
	irq_pkg::irq_num_t    f_num_hist [2];
	exc_pkg::fault_info_t f_fi0_hist [2];
	exc_pkg::fault_info_t f_fi1_hist [2];

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_dispatch();
		irq_pkg::irq_num_t    exp_num;
		exc_pkg::fault_info_t exp_fi0;
		exc_pkg::fault_info_t exp_fi1;
		int                   idx;
		idx = -1;
		dispatch_count++;
		if (outstanding) begin
			$display("Second handler started before the first one finished");
			error_count++;
		end
		outstanding = 1'b1;
		if (f_act_hist[1]) begin
			exp_num = f_num_hist[1];
			exp_fi0 = f_fi0_hist[1];
			exp_fi1 = f_fi1_hist[1];
		end else begin
			for (int i = 0; i < irq_pkg::IRQ_LINES; i++) begin
				if (idx < 0 && pend_model[i]) begin
					idx = i;
				end
			end
			if (idx < 0) begin
				$display("Handler %0d dispatched with no request pending", handler_num);
				error_count++;
				return;
			end
			if (enable_model[idx] && !mask_model[idx]) begin
				$display("Handler dispatched while lowest pending line %0d is masked", idx);
				error_count++;
			end
			pend_model[idx] = 1'b0;
			exp_num = irq_pkg::irq_num_t'(idx);
			exp_fi0 = '0;
			exp_fi1 = '0;
		end
		compare("handler_num", 32'(handler_num), 32'(exp_num));
		compare("handler_vector", handler_vector,
			VECTOR_BASE + 32'(exp_num) * VECTOR_STRIDE);
		compare("handler_fi0", handler_fi0, exp_fi0);
		compare("handler_fi1", handler_fi1, exp_fi1);
	endtask

	// Sampled mid-cycle where every DUT output is settled
	always @(negedge iCLOCK) begin
		if (!inRESET) begin
			compare("handler_valid", 32'(handler_valid), 32'h0);
			compare("exception_pending", 32'(exception_pending), 32'h0);
			pend_model = '0;
			mask_model = '0;
			enable_model = '0;
			outstanding = 1'b0;
			for (int i = 0; i < 2; i++) begin
				f_act_hist[i] = 1'b0;
			end
		end else begin
			if (handler_valid && !hv_prev) begin
				check_dispatch();
			end
			if (handler_done) begin
				outstanding = 1'b0;
			end
			if (ict_valid) begin
				mask_model[ict_entry]   = ict_mask;
				enable_model[ict_entry] = ict_enable;
			end
			pend_model = pend_model | irq_req;
			f_act_hist[1] = f_act_hist[0];
			f_num_hist[1] = f_num_hist[0];
			f_fi0_hist[1] = f_fi0_hist[0];
			f_fi1_hist[1] = f_fi1_hist[0];
			f_act_hist[0] = fault_active;
			f_num_hist[0] = fault_num;
			f_fi0_hist[0] = fault_fi0;
			f_fi1_hist[0] = fault_fi1;
		end
		hv_prev = handler_valid;
	end

endmodule

`default_nettype wire

/* rtl/interrupt_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module interrupt_subsystem #(
	parameter logic [31:0] VECTOR_BASE   = 32'h0000_1000,
	parameter logic [31:0] VECTOR_STRIDE = 32'd16
) (
	input  wire                          iCLOCK,
	input  wire                          inRESET,
	// External request lines
	input  wire [irq_pkg::IRQ_LINES-1:0] irq_req,
	// Configuration table write
	input  wire                          ict_valid,
	input  wire irq_pkg::ext_num_t       ict_entry,
	input  wire                          ict_mask,
	input  wire                          ict_enable,
	// Core fault
	input  wire                          fault_active,
	input  wire irq_pkg::irq_num_t       fault_num,
	input  wire exc_pkg::fault_info_t    fault_fi0,
	input  wire exc_pkg::fault_info_t    fault_fi1,
	input  wire                          handler_done,
	// Handler to the core
	output logic                         handler_valid,
	output irq_pkg::irq_num_t            handler_num,
	output logic [31:0]                  handler_vector,
	output exc_pkg::fault_info_t         handler_fi0,
	output exc_pkg::fault_info_t         handler_fi1,
	output logic                         exception_pending
);

	// Line stage to control stage
	logic              ext_active;
	irq_pkg::ext_num_t ext_num;
	logic              ext_ack;

	// Control stage to dispatch stage and back
	logic                 exception_taken;
	irq_pkg::irq_num_t    exception_num;
	exc_pkg::fault_info_t exception_fi0;
	exc_pkg::fault_info_t exception_fi1;
	logic                 irq_ack;
	logic                 exception_lock;

	irq_line_encoder u_irq_line_encoder (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.irq_req    (irq_req),
		.ext_ack    (ext_ack),
		.ext_active (ext_active),
		.ext_num    (ext_num)
	);

	interrupt_control u_interrupt_control (
		.iCLOCK           (iCLOCK),
		.inRESET          (inRESET),
		.ict_valid        (ict_valid),
		.ict_entry        (ict_entry),
		.ict_mask         (ict_mask),
		.ict_enable       (ict_enable),
		.ext_active       (ext_active),
		.ext_num          (ext_num),
		.ext_ack          (ext_ack),
		.fault_active     (fault_active),
		.fault_num        (fault_num),
		.fault_fi0        (fault_fi0),
		.fault_fi1        (fault_fi1),
		.exception_lock   (exception_lock),
		.exception_active (exception_pending),
		.exception_taken  (exception_taken),
		.exception_num    (exception_num),
		.exception_fi0    (exception_fi0),
		.exception_fi1    (exception_fi1),
		.irq_ack          (irq_ack)
	);

	exception_dispatch #(
		.VECTOR_BASE   (VECTOR_BASE),
		.VECTOR_STRIDE (VECTOR_STRIDE)
	) u_exception_dispatch (
		.iCLOCK          (iCLOCK),
		.inRESET         (inRESET),
		.exception_taken (exception_taken),
		.exception_num   (exception_num),
		.exception_fi0   (exception_fi0),
		.exception_fi1   (exception_fi1),
		.irq_ack         (irq_ack),
		.exception_lock  (exception_lock),
		.handler_done    (handler_done),
		.handler_valid   (handler_valid),
		.handler_num     (handler_num),
		.handler_vector  (handler_vector),
		.handler_fi0     (handler_fi0),
		.handler_fi1     (handler_fi1)
	);

endmodule

`default_nettype wire

/* rtl/exception_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module exception_dispatch #(
	parameter logic [31:0] VECTOR_BASE   = 32'h0000_1000,
	parameter logic [31:0] VECTOR_STRIDE = 32'd16
) (
	input  wire                       iCLOCK,
	input  wire                       inRESET,
	// Control stage
	input  wire                       exception_taken,
	input  wire irq_pkg::irq_num_t    exception_num,
	input  wire exc_pkg::fault_info_t exception_fi0,
	input  wire exc_pkg::fault_info_t exception_fi1,
	output logic                      irq_ack,
	output logic                      exception_lock,
	// Core
	input  wire                       handler_done,
	output logic                      handler_valid,
	output irq_pkg::irq_num_t         handler_num,
	output logic [31:0]               handler_vector,
	output exc_pkg::fault_info_t      handler_fi0,
	output exc_pkg::fault_info_t      handler_fi1
);

	exc_pkg::dispatch_state_t b_state;
	logic [31:0]              vector_calc;

	// Handler entry point, base plus number times stride
	assign vector_calc = VECTOR_BASE + 32'(exception_num) * VECTOR_STRIDE;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_state <= exc_pkg::DISP_IDLE;
			irq_ack <= 1'b0;
		end else begin
			irq_ack <= 1'b0;
			case (b_state)
				exc_pkg::DISP_IDLE: begin
					if (exception_taken) begin
						b_state <= exc_pkg::DISP_RUN;
						irq_ack <= 1'b1;
					end
				end
				exc_pkg::DISP_RUN: begin
					// Core reports the handler has finished
					if (handler_done) begin
						b_state <= exc_pkg::DISP_IDLE;
					end
				end
				default: begin
					b_state <= exc_pkg::DISP_IDLE;
				end
			endcase
		end
	end

	// Handler payload captured together with the transition to RUN
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			handler_num    <= '0;
			handler_vector <= '0;
			handler_fi0    <= '0;
			handler_fi1    <= '0;
		end else if (b_state == exc_pkg::DISP_IDLE && exception_taken) begin
			handler_num    <= exception_num;
			handler_vector <= vector_calc;
			handler_fi0    <= exception_fi0;
			handler_fi1    <= exception_fi1;
		end
	end

	assign handler_valid  = (b_state == exc_pkg::DISP_RUN);
	// Lock spans the whole handler run
	assign exception_lock = (b_state == exc_pkg::DISP_RUN);

	// Control stage must respect the lock and hand over only when idle
	taken_only_in_idle: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		exception_taken |-> (b_state == exc_pkg::DISP_IDLE)
	);

endmodule

`default_nettype wire

/* irq_ctrl/interrupt_control.sv */
`timescale 1ns/1ps
`default_nettype none

module interrupt_control (
	input  wire                      iCLOCK,
	input  wire                      inRESET,
	// Configuration table write
	input  wire                      ict_valid,
	input  wire irq_pkg::ext_num_t   ict_entry,
	input  wire                      ict_mask,
	input  wire                      ict_enable,
	// Line stage
	input  wire                      ext_active,
	input  wire irq_pkg::ext_num_t   ext_num,
	output logic                     ext_ack,
	// Software fault from the core
	input  wire                      fault_active,
	input  wire irq_pkg::irq_num_t   fault_num,
	input  wire exc_pkg::fault_info_t fault_fi0,
	input  wire exc_pkg::fault_info_t fault_fi1,
	// Dispatch stage
	input  wire                      exception_lock,
	output logic                     exception_active,
	output logic                     exception_taken,
	output irq_pkg::irq_num_t        exception_num,
	output exc_pkg::fault_info_t     exception_fi0,
	output exc_pkg::fault_info_t     exception_fi1,
	input  wire                      irq_ack
);

	// Configuration table
	logic [irq_pkg::IRQ_LINES-1:0] ict_mask_tbl;
	logic [irq_pkg::IRQ_LINES-1:0] ict_enable_tbl;

	exc_pkg::ctrl_state_t  b_state;
	logic                  b_hw_valid;
	irq_pkg::ext_num_t     b_hw_num;
	logic                  b_taken;
	logic                  b_taken_hw;
	irq_pkg::irq_num_t     b_exc_num;
	exc_pkg::fault_info_t  b_exc_fi0;
	exc_pkg::fault_info_t  b_exc_fi1;

	logic line_allowed;
	logic sw_valid;
	logic sw_accept;
	logic hw_accept;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			ict_mask_tbl   <= '0;
			ict_enable_tbl <= '0;
		end else if (ict_valid) begin
			ict_mask_tbl[ict_entry]   <= ict_mask;
			ict_enable_tbl[ict_entry] <= ict_enable;
		end
	end

	// Unconfigured entries pass, configured ones need the mask bit
	assign line_allowed = !ict_enable_tbl[ext_num] || ict_mask_tbl[ext_num];

	assign sw_valid  = fault_active && !exception_lock;
	assign sw_accept = (b_state == exc_pkg::CTRL_IDLE) && sw_valid;
	// Fault has priority over a latched line
	assign hw_accept = (b_state == exc_pkg::CTRL_IDLE) && !sw_valid &&
		b_hw_valid && !exception_lock;

	// Hardware latch, refreshed while idle so it tracks the lowest presented line
	// Cleared outside IDLE until the line stage shows the post-acknowledge state
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_hw_valid <= 1'b0;
			b_hw_num   <= '0;
		end else if (b_state == exc_pkg::CTRL_IDLE && !hw_accept) begin
			b_hw_valid <= ext_active && line_allowed;
			b_hw_num   <= ext_num;
		end else begin
			b_hw_valid <= 1'b0;
		end
	end

	// Control FSM
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_state    <= exc_pkg::CTRL_IDLE;
			b_taken    <= 1'b0;
			b_taken_hw <= 1'b0;
		end else begin
			case (b_state)
				exc_pkg::CTRL_IDLE: begin
					if (sw_accept || hw_accept) begin
						b_state    <= exc_pkg::CTRL_COMP_WAIT;
						b_taken    <= 1'b1;
						b_taken_hw <= hw_accept;
					end
				end
				exc_pkg::CTRL_COMP_WAIT: begin
					b_taken    <= 1'b0;
					b_taken_hw <= 1'b0;
					if (irq_ack) begin
						b_state <= exc_pkg::CTRL_IDLE;
					end
				end
				default: begin
					b_state    <= exc_pkg::CTRL_IDLE;
					b_taken    <= 1'b0;
					b_taken_hw <= 1'b0;
				end
			endcase
		end
	end

	// Frozen exception, held through COMP_WAIT
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_exc_num <= '0;
			b_exc_fi0 <= '0;
			b_exc_fi1 <= '0;
		end else if (sw_accept) begin
			b_exc_num <= fault_num;
			b_exc_fi0 <= fault_fi0;
			b_exc_fi1 <= fault_fi1;
		end else if (hw_accept) begin
			b_exc_num <= {1'b0, b_hw_num};
			// No fault information for external lines
			b_exc_fi0 <= '0;
			b_exc_fi1 <= '0;
		end
	end

	assign ext_ack         = b_taken && b_taken_hw;
	assign exception_taken = b_taken;
	assign exception_num   = b_exc_num;
	assign exception_fi0   = b_exc_fi0;
	assign exception_fi1   = b_exc_fi1;

	// Something is waiting or in flight toward the dispatch stage
	always_comb begin
		if (b_state == exc_pkg::CTRL_COMP_WAIT) begin
			exception_active = !irq_ack;
		end else begin
			exception_active = sw_valid || b_hw_valid ||
				(ext_active && line_allowed && !exception_lock);
		end
	end

	// Dispatch acknowledges only a taken exception
	irq_ack_in_comp_wait: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		irq_ack |-> (b_state == exc_pkg::CTRL_COMP_WAIT)
	);

	// Nothing is handed over while a handler is outstanding
	no_take_under_lock: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		exception_taken |-> !exception_lock
	);

endmodule

`default_nettype wire

/* irq_ctrl/irq_line_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module irq_line_encoder (
	input  wire                            iCLOCK,
	input  wire                            inRESET,
	input  wire [irq_pkg::IRQ_LINES-1:0]   irq_req,
	input  wire                            ext_ack,
	output logic                           ext_active,
	output irq_pkg::ext_num_t              ext_num
);

	logic [irq_pkg::IRQ_LINES-1:0] pending;
	logic [irq_pkg::IRQ_LINES-1:0] ack_clr;
	logic                          low_found;
	irq_pkg::ext_num_t             low_num;

	// Bit to drop when the control stage takes the presented line
	always_comb begin
		ack_clr = '0;
		if (ext_ack) begin
			ack_clr[ext_num] = 1'b1;
		end
	end

	// Sticky pending bits
	// A pulse in the acknowledge cycle keeps the bit set
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pending <= '0;
		end else begin
			pending <= (pending & ~ack_clr) | irq_req;
		end
	end

	// Lowest set index, scanned from the top so the last hit wins
	always_comb begin
		low_found = 1'b0;
		low_num   = '0;
		for (int i = irq_pkg::IRQ_LINES - 1; i >= 0; i--) begin
			if (pending[i]) begin
				low_found = 1'b1;
				low_num   = irq_pkg::ext_num_t'(i);
			end
		end
	end

	// Registered presentation to the control stage
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			ext_active <= 1'b0;
			ext_num    <= '0;
		end else begin
			ext_active <= low_found;
			ext_num    <= low_num;
		end
	end

	// The control stage may only take a line that is presented
	ack_only_when_active: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		ext_ack |-> ext_active
	);

endmodule

`default_nettype wire

/* common/exc_pkg.sv */
`default_nettype none

package exc_pkg;

	// One fault-information word
	localparam int FAULT_INFO_W = 32;

	typedef logic [FAULT_INFO_W-1:0] fault_info_t;

	// Control stage FSM
	// IDLE accepts a new exception, COMP_WAIT waits for the dispatch acknowledge
	typedef enum logic [1:0] {
		CTRL_IDLE      = 2'd0,
		CTRL_COMP_WAIT = 2'd1
	} ctrl_state_t;

	// Dispatch stage FSM
	// RUN means a handler is outstanding on the core
	typedef enum logic {
		DISP_IDLE = 1'b0,
		DISP_RUN  = 1'b1
	} dispatch_state_t;

endpackage

`default_nettype wire

/* common/irq_pkg.sv */
`default_nettype none

package irq_pkg;

	// External request lines, one configuration entry per line
	localparam int IRQ_LINES = 64;

	// Width of an external line number
	localparam int EXT_NUM_W = 6;

	// Width of an exception number, hardware and software share this space
	localparam int IRQ_NUM_W = 7;

	// External line index 0..63
	typedef logic [EXT_NUM_W-1:0] ext_num_t;

	// Exception number
	// Hardware lines are zero-extended, software faults use all 7 bits
	typedef logic [IRQ_NUM_W-1:0] irq_num_t;

endpackage

`default_nettype wire
